// File: verilog/mem_pkg.sv
package mem_pkg;

    // Memory transaction tags
    localparam int MEM_TAG_BITS = 4;

    // Tag zero never names a live transaction
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    localparam mem_tag_t NO_MEM_TAG = '0;

    // One memory block carries two 32-bit instruction words
    localparam int MEM_BLOCK_BITS = 64;

    // Word 0 sits in the low half
    typedef logic [MEM_BLOCK_BITS-1:0] mem_block_t;

endpackage

// File: verilog/icache_pkg.sv
package icache_pkg;

    // Fetch-side byte address
    typedef logic [31:0] addr_t;

    // Byte offset inside one block
    localparam int BLOCK_OFFSET_BITS = 3;

    // Address step between consecutive blocks
    localparam int BLOCK_BYTES = 8;

    // Block tag is address bits 15 to 3, upper half is always zero
    localparam int ITAG_BITS = 13;

    typedef logic [ITAG_BITS-1:0] itag_t;

    // Fetch reads per cycle, port 0 holds the older instruction
    localparam int READ_PORTS = 2;

    // One fully associative line
    typedef struct packed {
        logic                valid;
        itag_t               tag;
        mem_pkg::mem_block_t data;
    } cache_line_t;

endpackage

// File: verilog/icache_array.sv
`timescale 1ns/1ps

module icache_array #(
    parameter int NUM_LINES = 8
) (
    input  logic                                         i_clock,
    input  logic                                         i_reset,

    input  logic [icache_pkg::READ_PORTS-1:0]            i_read_valid,
    input  icache_pkg::addr_t [icache_pkg::READ_PORTS-1:0] i_read_addr,
    output logic [icache_pkg::READ_PORTS-1:0]            o_read_hit,
    output mem_pkg::mem_block_t [icache_pkg::READ_PORTS-1:0] o_read_data,

    input  logic                                         i_probe_valid,
    input  icache_pkg::addr_t                            i_probe_addr,
    output logic                                         o_probe_found,
    output logic                                         o_full,

    input  logic                                         i_fill_valid,
    input  icache_pkg::itag_t                            i_fill_tag,
    input  mem_pkg::mem_block_t                          i_fill_data
);
    import icache_pkg::*;

    localparam int IDX_BITS = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;

    cache_line_t                          lines [NUM_LINES];
    logic [NUM_LINES-1:0]                 line_valid;
    logic [READ_PORTS-1:0][NUM_LINES-1:0] read_match;
    logic [NUM_LINES-1:0]                 probe_match;
    logic [NUM_LINES-1:0]                 fill_match;
    itag_t                                probe_tag;
    logic                                 free_found;
    logic [IDX_BITS-1:0]                  free_idx;
    logic [IDX_BITS-1:0]                  victim_ptr;
    logic [IDX_BITS-1:0]                  fill_idx;

    assign probe_tag = i_probe_addr[BLOCK_OFFSET_BITS +: ITAG_BITS];

    // Tag compare against every line for reads, probe and fill
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            line_valid[i]  = lines[i].valid;
            probe_match[i] = i_probe_valid && lines[i].valid && (lines[i].tag == probe_tag);
            fill_match[i]  = lines[i].valid && (lines[i].tag == i_fill_tag);
            for (int p = 0; p < READ_PORTS; p++) begin
                read_match[p][i] = i_read_valid[p] && lines[i].valid &&
                    (lines[i].tag == i_read_addr[p][BLOCK_OFFSET_BITS +: ITAG_BITS]);
            end
        end
    end

    // Tags are unique, so at most one line drives each port
    always_comb begin
        o_read_data = '0;
        for (int p = 0; p < READ_PORTS; p++) begin
            o_read_hit[p] = |read_match[p];
            for (int i = 0; i < NUM_LINES; i++) begin
                if (read_match[p][i]) begin
                    o_read_data[p] = lines[i].data;
                end
            end
        end
    end

    assign o_probe_found = |probe_match;
    assign o_full        = &line_valid;

    // Lowest-index free line, scanned downward so the lowest wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NUM_LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_BITS'(i);
            end
        end
    end

    assign fill_idx = free_found ? free_idx : victim_ptr;

    // Rotating victim, moves only when a valid line is replaced
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            victim_ptr <= '0;
        end else if (i_fill_valid && !free_found) begin
            if (victim_ptr == IDX_BITS'(NUM_LINES - 1)) begin
                victim_ptr <= '0;
            end else begin
                victim_ptr <= victim_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (i_fill_valid) begin
            lines[fill_idx] <= '{valid: 1'b1, tag: i_fill_tag, data: i_fill_data};
        end
    end

    // Probing of cache and miss tracker keeps a block from being fetched twice
    a_fill_unique: assert property (@(posedge i_clock) disable iff (i_reset)
        i_fill_valid |-> (fill_match == '0));

endmodule

// File: verilog/icache_prefetcher.sv
`timescale 1ns/1ps

module icache_prefetcher (
    input  logic              i_clock,
    input  logic              i_reset,

    input  logic              i_miss_valid,
    input  icache_pkg::addr_t i_miss_addr,
    input  logic              i_cache_full,

    input  logic              i_cache_found,
    input  logic              i_mshr_found,
    output logic              o_probe_valid,
    output icache_pkg::addr_t o_probe_addr,

    output logic              o_mem_req_valid,
    output icache_pkg::addr_t o_mem_req_addr,
    input  logic              i_mem_req_accepted
);
    import icache_pkg::*;

    logic  last_miss_valid;
    addr_t last_miss_addr;
    addr_t lookahead_addr;
    addr_t miss_block;
    logic  miss_mode;
    logic  found;
    logic  advance;

    assign miss_block = {i_miss_addr[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};

    // A new miss takes over from the lookahead stream
    assign miss_mode = i_miss_valid && (!last_miss_valid || (miss_block != last_miss_addr));

    assign found = i_cache_found || i_mshr_found;

    always_comb begin
        o_probe_valid = 1'b0;
        o_probe_addr  = lookahead_addr + addr_t'(BLOCK_BYTES);
        if (miss_mode) begin
            o_probe_valid = 1'b1;
            o_probe_addr  = miss_block;
        end else if (last_miss_valid && !i_cache_full) begin
            o_probe_valid = 1'b1;
        end
    end

    // Blocks already cached or pending are skipped, not requested
    assign o_mem_req_valid = o_probe_valid && !found;
    assign o_mem_req_addr  = o_probe_addr;

    assign advance = o_probe_valid && (i_mem_req_accepted || found);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_miss_valid <= 1'b0;
            last_miss_addr  <= '0;
            lookahead_addr  <= '0;
        end else if (advance) begin
            if (miss_mode) begin
                last_miss_valid <= 1'b1;
                last_miss_addr  <= miss_block;
            end
            lookahead_addr <= o_probe_addr;
        end
    end

endmodule

// File: verilog/icache_mshr.sv
`timescale 1ns/1ps

module icache_mshr #(
    parameter int MSHR_DEPTH = 16
) (
    input  logic              i_clock,
    input  logic              i_reset,

    input  icache_pkg::itag_t i_probe_tag,
    output logic              o_probe_found,

    input  logic              i_push,
    input  mem_pkg::mem_tag_t i_push_mem_tag,
    input  icache_pkg::itag_t i_push_tag,

    input  mem_pkg::mem_tag_t i_ret_mem_tag,
    output logic              o_fill_valid,
    output icache_pkg::itag_t o_fill_tag
);
    import icache_pkg::*;
    import mem_pkg::*;

    localparam int PTR_BITS = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;

    logic [MSHR_DEPTH-1:0] entry_valid;
    mem_tag_t              entry_mem_tag [MSHR_DEPTH];
    itag_t                 entry_tag [MSHR_DEPTH];
    logic [PTR_BITS-1:0]   head;
    logic [PTR_BITS-1:0]   tail;
    logic [MSHR_DEPTH-1:0] probe_match;
    logic                  push_ok;
    logic                  pop;

    // Zero tag means memory took nothing
    assign push_ok = i_push && (i_push_mem_tag != NO_MEM_TAG);

    // Memory returns in order, so only the head may retire
    assign pop = (i_ret_mem_tag != NO_MEM_TAG) && entry_valid[head] &&
                 (i_ret_mem_tag == entry_mem_tag[head]);

    assign o_fill_valid = pop;
    assign o_fill_tag   = entry_tag[head];

    always_comb begin
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            probe_match[i] = entry_valid[i] && (entry_tag[i] == i_probe_tag);
        end
    end

    assign o_probe_found = |probe_match;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
        end else begin
            if (pop) begin
                entry_valid[head] <= 1'b0;
                head <= (head == PTR_BITS'(MSHR_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (push_ok) begin
                entry_valid[tail] <= 1'b1;
                tail <= (tail == PTR_BITS'(MSHR_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge i_clock) begin
        if (push_ok) begin
            entry_mem_tag[tail] <= i_push_mem_tag;
            entry_tag[tail]     <= i_push_tag;
        end
    end

    // Memory never has more tags in flight than there are entries
    a_no_push_full: assert property (@(posedge i_clock) disable iff (i_reset)
        push_ok |-> !entry_valid[tail]);

endmodule

// File: verilog/icache_subsystem.sv
`timescale 1ns/1ps

module icache_subsystem #(
    parameter int NUM_LINES  = 8,
    parameter int MSHR_DEPTH = 16
) (
    input  logic                                           i_clock,
    input  logic                                           i_reset,

    input  logic [icache_pkg::READ_PORTS-1:0]              i_read_valid,
    input  icache_pkg::addr_t [icache_pkg::READ_PORTS-1:0] i_read_addr,
    output logic [icache_pkg::READ_PORTS-1:0]              o_read_hit,
    output mem_pkg::mem_block_t [icache_pkg::READ_PORTS-1:0] o_read_data,

    output logic                                           o_mem_req_valid,
    output icache_pkg::addr_t                              o_mem_req_addr,
    input  logic                                           i_mem_req_accepted,
    input  mem_pkg::mem_tag_t                              i_mem_req_tag,

    input  mem_pkg::mem_tag_t                              i_mem_data_tag,
    input  mem_pkg::mem_block_t                            i_mem_data
);
    import icache_pkg::*;
    import mem_pkg::*;

    logic     miss_valid;
    addr_t    miss_addr;
    logic     probe_valid;
    addr_t    probe_addr;
    logic     cache_full;
    logic     cache_found;
    logic     mshr_found;
    logic     fill_valid;
    itag_t    fill_tag;
    mem_tag_t push_mem_tag;

    // Oldest miss, port 0 first
    always_comb begin
        miss_valid = 1'b0;
        miss_addr  = i_read_addr[0];
        if (i_read_valid[0] && !o_read_hit[0]) begin
            miss_valid = 1'b1;
        end else if (i_read_valid[1] && !o_read_hit[1]) begin
            miss_valid = 1'b1;
            miss_addr  = i_read_addr[1];
        end
    end

    assign push_mem_tag = i_mem_req_accepted ? i_mem_req_tag : NO_MEM_TAG;

    icache_array #(
        .NUM_LINES(NUM_LINES)
    ) icache_array_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_read_valid (i_read_valid),
        .i_read_addr  (i_read_addr),
        .o_read_hit   (o_read_hit),
        .o_read_data  (o_read_data),
        .i_probe_valid(probe_valid),
        .i_probe_addr (probe_addr),
        .o_probe_found(cache_found),
        .o_full       (cache_full),
        .i_fill_valid (fill_valid),
        .i_fill_tag   (fill_tag),
        .i_fill_data  (i_mem_data)
    );

    icache_prefetcher icache_prefetcher_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_miss_valid      (miss_valid),
        .i_miss_addr       (miss_addr),
        .i_cache_full      (cache_full),
        .i_cache_found     (cache_found),
        .i_mshr_found      (mshr_found),
        .o_probe_valid     (probe_valid),
        .o_probe_addr      (probe_addr),
        .o_mem_req_valid   (o_mem_req_valid),
        .o_mem_req_addr    (o_mem_req_addr),
        .i_mem_req_accepted(i_mem_req_accepted)
    );

    icache_mshr #(
        .MSHR_DEPTH(MSHR_DEPTH)
    ) icache_mshr_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_probe_tag   (probe_addr[BLOCK_OFFSET_BITS +: ITAG_BITS]),
        .o_probe_found (mshr_found),
        .i_push        (i_mem_req_accepted),
        .i_push_mem_tag(push_mem_tag),
        .i_push_tag    (o_mem_req_addr[BLOCK_OFFSET_BITS +: ITAG_BITS]),
        .i_ret_mem_tag (i_mem_data_tag),
        .o_fill_valid  (fill_valid),
        .o_fill_tag    (fill_tag)
    );

    // Memory may only take a request that is being offered
    a_accept_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
        i_mem_req_accepted |-> o_mem_req_valid);

endmodule

// File: verif/icache_subsystem_tb.sv
`timescale 1ns/1ps

module icache_subsystem_tb;
    import icache_pkg::*;
    import mem_pkg::*;

    localparam int NUM_LINES   = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int REQ_WAIT    = 8;
    // Six short tests of well under 200 cycles each leave a wide margin
    localparam int MAX_CYCLES  = 2000;

    logic                   clock;
    logic                   reset;
    logic [READ_PORTS-1:0]  read_valid;
    addr_t [READ_PORTS-1:0] read_addr;
    logic [READ_PORTS-1:0]  read_hit;
    mem_block_t [READ_PORTS-1:0] read_data;
    logic                   mem_req_valid;
    addr_t                  mem_req_addr;
    logic                   mem_req_accepted;
    mem_tag_t               mem_req_tag;
    mem_tag_t               mem_data_tag;
    mem_block_t             mem_data;

    // Expected cache lines and requests still out at memory
    logic       line_valid [NUM_LINES];
    addr_t      line_addr [NUM_LINES];
    mem_block_t line_data [NUM_LINES];
    int         victim;
    mem_tag_t   pend_tag [$];
    addr_t      pend_addr [$];
    int         errors;
    int         cycles;
    int         seed;

    icache_subsystem #(
        .NUM_LINES (NUM_LINES),
        .MSHR_DEPTH(16)
    ) icache_subsystem_i (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_read_valid      (read_valid),
        .i_read_addr       (read_addr),
        .o_read_hit        (read_hit),
        .o_read_data       (read_data),
        .o_mem_req_valid   (mem_req_valid),
        .o_mem_req_addr    (mem_req_addr),
        .i_mem_req_accepted(mem_req_accepted),
        .i_mem_req_tag     (mem_req_tag),
        .i_mem_data_tag    (mem_data_tag),
        .i_mem_data        (mem_data)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic addr_t block_of(input addr_t addr);
        return {addr[31:3], 3'b000};
    endfunction

    // Memory strobes last one edge
    task automatic step();
        @(posedge clock);
        #DRIVE_DELAY;
        mem_req_accepted = 1'b0;
        mem_data_tag     = NO_MEM_TAG;
    endtask

    task automatic apply_reset();
        reset      = 1'b1;
        read_valid = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            line_valid[i] = 1'b0;
        end
        victim = 0;
        pend_tag.delete();
        pend_addr.delete();
        repeat (4) step();
        reset = 1'b0;
    endtask

    task automatic set_reads(input logic [1:0] valid, input addr_t a0, input addr_t a1);
        read_valid   = valid;
        read_addr[0] = a0;
        read_addr[1] = a1;
    endtask

    task automatic expect_request(input addr_t addr);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!mem_req_valid && waited < REQ_WAIT) begin
            step();
            @(negedge clock);
            waited++;
        end
        if (!mem_req_valid) begin
            $display("No memory request for block %h within %0d cycles", addr, REQ_WAIT);
            errors++;
        end else if (mem_req_addr !== addr) begin
            $display("CHECK FAILED o_mem_req_addr expected %h actual %h", addr, mem_req_addr);
            errors++;
        end
        step();
    endtask

    // An unaccepted request stays up with the same address
    task automatic expect_held_request(input addr_t addr);
        @(negedge clock);
        if (mem_req_valid !== 1'b1) begin
            $display("CHECK FAILED o_mem_req_valid expected 1 actual %h", mem_req_valid);
            errors++;
        end else if (mem_req_addr !== addr) begin
            $display("CHECK FAILED o_mem_req_addr expected %h actual %h", addr, mem_req_addr);
            errors++;
        end
        step();
    endtask

    task automatic expect_no_request();
        @(negedge clock);
        if (mem_req_valid !== 1'b0) begin
            $display("CHECK FAILED o_mem_req_valid expected 0 actual %h", mem_req_valid);
            errors++;
        end
        step();
    endtask

    // Request is still held in the cycle after it was seen
    task automatic accept_request(input addr_t addr, input mem_tag_t tag);
        expect_request(addr);
        mem_req_accepted = 1'b1;
        mem_req_tag      = tag;
        pend_tag.push_back(tag);
        pend_addr.push_back(addr);
        step();
    endtask

    task automatic model_fill(input addr_t addr, input mem_block_t data);
        int idx;
        idx = -1;
        for (int i = NUM_LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            idx    = victim;
            victim = (victim + 1) % NUM_LINES;
        end
        line_valid[idx] = 1'b1;
        line_addr[idx]  = addr;
        line_data[idx]  = data;
    endtask

    // Only the oldest outstanding tag fills a line
    task automatic return_data(input mem_tag_t tag);
        mem_block_t data;
        data         = {$random(seed), $random(seed)};
        mem_data_tag = tag;
        mem_data     = data;
        if (pend_tag.size() > 0 && pend_tag[0] == tag) begin
            model_fill(pend_addr[0], data);
            void'(pend_tag.pop_front());
            void'(pend_addr.pop_front());
        end
        step();
    endtask

    task automatic check_reads(input addr_t a0, input addr_t a1);
        addr_t      addr [2];
        logic       hit;
        mem_block_t data;
        addr[0] = a0;
        addr[1] = a1;
        set_reads(2'b11, a0, a1);
        @(negedge clock);
        for (int p = 0; p < READ_PORTS; p++) begin
            hit  = 1'b0;
            data = '0;
            for (int i = 0; i < NUM_LINES; i++) begin
                if (line_valid[i] && line_addr[i] == block_of(addr[p])) begin
                    hit  = 1'b1;
                    data = line_data[i];
                end
            end
            if (read_hit[p] !== hit) begin
                $display("CHECK FAILED o_read_hit[%0d] expected %h actual %h",
                         p, hit, read_hit[p]);
                errors++;
            end else if (hit && read_data[p] !== data) begin
                $display("CHECK FAILED o_read_data[%0d] expected %h actual %h",
                         p, data, read_data[p]);
                errors++;
            end
        end
        step();
    endtask

    task automatic test_reset_state();
        apply_reset();
        expect_no_request();
        check_reads(32'h0000_1000, 32'h0000_2468);
    endtask

    task automatic test_miss_fill();
        apply_reset();
        set_reads(2'b01, 32'h0000_1234, '0);
        accept_request(32'h0000_1230, 4'd1);
        return_data(4'd1);
        check_reads(32'h0000_1230, 32'h0000_1236);
    endtask

    task automatic test_prefetch();
        apply_reset();
        set_reads(2'b01, 32'h0000_2000, '0);
        accept_request(32'h0000_2000, 4'd1);
        expect_request(32'h0000_2008);
        expect_held_request(32'h0000_2008);
        accept_request(32'h0000_2008, 4'd2);
        accept_request(32'h0000_2010, 4'd3);
        accept_request(32'h0000_2018, 4'd4);
        for (int t = 1; t <= 4; t++) begin
            return_data(mem_tag_t'(t));
        end
        // With all four lines valid nothing more is fetched
        expect_no_request();
        check_reads(32'h0000_2000, 32'h0000_2008);
        check_reads(32'h0000_2010, 32'h0000_2018);
        expect_no_request();
    endtask

    task automatic test_in_order();
        apply_reset();
        set_reads(2'b01, 32'h0000_3000, '0);
        accept_request(32'h0000_3000, 4'd5);
        accept_request(32'h0000_3008, 4'd6);
        return_data(4'd6);
        check_reads(32'h0000_3000, 32'h0000_3008);
        return_data(4'd5);
        check_reads(32'h0000_3000, 32'h0000_3008);
    endtask

    task automatic test_eviction();
        apply_reset();
        set_reads(2'b01, 32'h0000_4000, '0);
        accept_request(32'h0000_4000, 4'd1);
        accept_request(32'h0000_4008, 4'd2);
        accept_request(32'h0000_4010, 4'd3);
        accept_request(32'h0000_4018, 4'd4);
        for (int t = 1; t <= 4; t++) begin
            return_data(mem_tag_t'(t));
        end
        set_reads(2'b01, 32'h0000_5000, '0);
        accept_request(32'h0000_5000, 4'd5);
        return_data(4'd5);
        check_reads(32'h0000_4000, 32'h0000_5000);
        set_reads(2'b01, 32'h0000_6000, '0);
        accept_request(32'h0000_6000, 4'd6);
        return_data(4'd6);
        check_reads(32'h0000_4008, 32'h0000_6000);
        check_reads(32'h0000_4010, 32'h0000_4018);
    endtask

    task automatic test_priority();
        apply_reset();
        set_reads(2'b11, 32'h0000_7004, 32'h0000_7100);
        accept_request(32'h0000_7000, 4'd1);
        // Port 0 block is pending, so the lookahead goes next
        accept_request(32'h0000_7008, 4'd2);
        set_reads(2'b01, 32'h0000_7008, '0);
        expect_no_request();
        set_reads(2'b10, '0, 32'h0000_7100);
        expect_request(32'h0000_7100);
    endtask

    initial begin
        seed             = 32'h059c72be;
        errors           = 0;
        cycles           = 0;
        clock            = 1'b0;
        reset            = 1'b1;
        read_valid       = '0;
        read_addr        = '0;
        mem_req_accepted = 1'b0;
        mem_req_tag      = NO_MEM_TAG;
        mem_data_tag     = NO_MEM_TAG;
        mem_data         = '0;
        test_reset_state();
        test_miss_fill();
        test_prefetch();
        test_in_order();
        test_eviction();
        test_priority();
        $display("Finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/mem_pkg.sv
verilog/icache_pkg.sv
verilog/icache_array.sv
verilog/icache_prefetcher.sv
verilog/icache_mshr.sv
verilog/icache_subsystem.sv
verif/icache_subsystem_tb.sv

// File: Makefile
SIM      = verilator
TOP      = icache_subsystem_tb
FILELIST = tb.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)
